// File: arp_pkg.sv
package arp_pkg;

	// fixed ARP header fields for Ethernet / IPv4
	localparam logic [15:0] arp_htype = 16'h0001;
	localparam logic [15:0] arp_ptype = 16'h0800;
	localparam logic [7:0] arp_hlen = 8'h06;
	localparam logic [7:0] arp_plen = 8'h04;

	localparam logic [15:0] arp_oper_request = 16'h0001;
	localparam logic [15:0] arp_oper_reply = 16'h0002;

	localparam logic [47:0] arp_broadcast_mac = 48'hffff_ffff_ffff;

	// 28 byte packet sent as 32 bit words
	localparam int arp_frame_words = 7;
	localparam int word_idx_w = $clog2(arp_frame_words);

	// word slots granted by the send buffer after reset
	localparam int tx_credits = 4;
	localparam int tx_credit_w = $clog2(tx_credits + 1);

	localparam int queue_depth = 4;
	localparam int queue_ptr_w = $clog2(queue_depth);
	localparam int queue_count_w = $clog2(queue_depth + 1);

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;

	// request only needs the target IP
	typedef struct packed {
		ip_addr_t tpa;
	} arp_request_t;

	typedef struct packed {
		ip_addr_t tpa;
		mac_addr_t tha;
	} arp_reply_t;

	// one word toward the send buffer
	typedef struct packed {
		logic [31:0] data;
		logic sof;
		logic eof;
	} arp_word_t;

endpackage

// File: arp_pending_queue.sv
`timescale 1ns/1ps

module arp_pending_queue #(
	parameter type entry_t = arp_pkg::arp_request_t
) (
	input logic clk,
	input logic reset,
	input logic push_valid,
	input entry_t push_entry,
	input logic pop,
	output logic push_ready,
	output logic not_empty,
	output entry_t head
);

	entry_t mem [arp_pkg::queue_depth];
	logic [arp_pkg::queue_ptr_w-1:0] wr_ptr;
	logic [arp_pkg::queue_ptr_w-1:0] rd_ptr;
	logic [arp_pkg::queue_count_w-1:0] count;
	logic push_fire;

	assign push_ready = (count != arp_pkg::queue_count_w'(arp_pkg::queue_depth));
	assign not_empty = (count != '0);
	assign head = mem[rd_ptr];
	assign push_fire = push_valid && push_ready;

	// storage holds payload only
	always_ff @(posedge clk) begin
		if (push_fire) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire) begin
				if (wr_ptr == arp_pkg::queue_ptr_w'(arp_pkg::queue_depth - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				if (rd_ptr == arp_pkg::queue_ptr_w'(arp_pkg::queue_depth - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			case ({push_fire, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the transmitter must only take the head when one is there
	a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> not_empty);

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= arp_pkg::queue_count_w'(arp_pkg::queue_depth));

endmodule

// File: arp_frame_tx.sv
`timescale 1ns/1ps

module arp_frame_tx (
	input logic clk,
	input logic reset,
	input arp_pkg::mac_addr_t local_mac,
	input arp_pkg::ip_addr_t local_ip,
	input logic req_pending,
	input arp_pkg::arp_request_t req_head,
	input logic rep_pending,
	input arp_pkg::arp_reply_t rep_head,
	input logic credit_return,
	output logic req_pop,
	output logic rep_pop,
	output logic word_valid,
	output arp_pkg::arp_word_t word,
	output arp_pkg::mac_addr_t dest_mac
);

	localparam logic [arp_pkg::word_idx_w-1:0] last_word =
		arp_pkg::word_idx_w'(arp_pkg::arp_frame_words - 1);

	// control state
	logic busy;
	logic [arp_pkg::word_idx_w-1:0] word_cnt;
	logic [arp_pkg::tx_credit_w-1:0] credits;

	// latched packet fields
	logic [15:0] pkt_oper;
	arp_pkg::ip_addr_t pkt_tpa;
	arp_pkg::mac_addr_t pkt_tha;

	logic send;
	logic last_send;
	logic load;
	logic [31:0] word_data;

	assign send = busy && (credits != '0);
	assign last_send = send && (word_cnt == last_word);

	// take a new entry when idle or as the current packet finishes
	assign load = !busy || last_send;
	assign req_pop = load && req_pending;
	assign rep_pop = load && !req_pending && rep_pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			word_cnt <= '0;
		end else begin
			if (req_pop || rep_pop)
				busy <= 1'b1;
			else if (last_send)
				busy <= 1'b0;

			if (last_send)
				word_cnt <= '0;
			else if (send)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req_pop) begin
			pkt_oper <= arp_pkg::arp_oper_request;
			pkt_tpa <= req_head.tpa;
			pkt_tha <= '0;
		end else if (rep_pop) begin
			pkt_oper <= arp_pkg::arp_oper_reply;
			pkt_tpa <= rep_head.tpa;
			pkt_tha <= rep_head.tha;
		end
	end

	// one credit per word sent, one back per return pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= arp_pkg::tx_credit_w'(arp_pkg::tx_credits);
		end else begin
			case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_comb begin
		case (word_cnt)
			3'd0: word_data = {arp_pkg::arp_htype, arp_pkg::arp_ptype};
			3'd1: word_data = {arp_pkg::arp_hlen, arp_pkg::arp_plen, pkt_oper};
			3'd2: word_data = local_mac[47:16];
			3'd3: word_data = {local_mac[15:0], local_ip[31:16]};
			3'd4: word_data = {local_ip[15:0], pkt_tha[47:32]};
			3'd5: word_data = pkt_tha[31:0];
			default: word_data = pkt_tpa;
		endcase
	end

	assign word_valid = send;
	assign word.data = word_data;
	assign word.sof = (word_cnt == '0);
	assign word.eof = (word_cnt == last_word);

	// requests go out broadcast, replies straight to the asking host
	assign dest_mac = (pkt_oper == arp_pkg::arp_oper_request) ?
		arp_pkg::arp_broadcast_mac : pkt_tha;

	// an empty counter only refills through a return pulse
	a_no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
		(credits == '0 && !credit_return) |=> !word_valid);

	// the sink must never return more slots than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= arp_pkg::tx_credit_w'(arp_pkg::tx_credits));

	// the cycle after a pop is the first word slot of that packet
	a_single_pop: assert property (@(posedge clk) disable iff (reset)
		(req_pop || rep_pop) |=> !(req_pop || rep_pop));

endmodule

// File: arp_tx_top.sv
`timescale 1ns/1ps

module arp_tx_top (
	input logic clk,
	input logic reset,
	input arp_pkg::mac_addr_t local_mac,
	input arp_pkg::ip_addr_t local_ip,
	input logic req_valid,
	input arp_pkg::arp_request_t req_entry,
	input logic rep_valid,
	input arp_pkg::arp_reply_t rep_entry,
	input logic credit_return,
	output logic req_ready,
	output logic rep_ready,
	output logic word_valid,
	output arp_pkg::arp_word_t word,
	output arp_pkg::mac_addr_t dest_mac
);

	logic req_pending;
	logic rep_pending;
	logic req_pop;
	logic rep_pop;
	arp_pkg::arp_request_t req_head;
	arp_pkg::arp_reply_t rep_head;

	// pending ARP requests, target IP only
	arp_pending_queue #(
		.entry_t(arp_pkg::arp_request_t)
	) req_queue (
		.clk(clk),
		.reset(reset),
		.push_valid(req_valid),
		.push_entry(req_entry),
		.pop(req_pop),
		.push_ready(req_ready),
		.not_empty(req_pending),
		.head(req_head)
	);

	// pending ARP replies, target IP and MAC
	arp_pending_queue #(
		.entry_t(arp_pkg::arp_reply_t)
	) rep_queue (
		.clk(clk),
		.reset(reset),
		.push_valid(rep_valid),
		.push_entry(rep_entry),
		.pop(rep_pop),
		.push_ready(rep_ready),
		.not_empty(rep_pending),
		.head(rep_head)
	);

	arp_frame_tx frame_tx (
		.clk(clk),
		.reset(reset),
		.local_mac(local_mac),
		.local_ip(local_ip),
		.req_pending(req_pending),
		.req_head(req_head),
		.rep_pending(rep_pending),
		.rep_head(rep_head),
		.credit_return(credit_return),
		.req_pop(req_pop),
		.rep_pop(rep_pop),
		.word_valid(word_valid),
		.word(word),
		.dest_mac(dest_mac)
	);

endmodule

// File: arp_tx_tb.sv
`timescale 1ns/1ps

module arp_tx_tb;

	typedef struct packed {
		logic [15:0] oper;
		arp_pkg::ip_addr_t tpa;
		arp_pkg::mac_addr_t tha;
		arp_pkg::mac_addr_t dest;
	} exp_rec_t;

	localparam int max_records = 64;
	localparam arp_pkg::mac_addr_t my_mac = 48'h0200_5e10_2030;
	localparam arp_pkg::ip_addr_t my_ip = 32'hc0a8_0164;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	logic rep_valid;
	logic credit_return;
	arp_pkg::arp_request_t req_entry;
	arp_pkg::arp_reply_t rep_entry;
	logic req_ready;
	logic rep_ready;
	logic word_valid;
	arp_pkg::arp_word_t word;
	arp_pkg::mac_addr_t dest_mac;

	// six 48 bit fields per record, see the data file header
	logic [47:0] data_mem [0:6*max_records-1];
	exp_rec_t exp_req[$];
	exp_rec_t exp_rep[$];
	int unsigned due[$];
	arp_pkg::arp_word_t pkt_words [arp_pkg::arp_frame_words];
	arp_pkg::mac_addr_t pkt_dest;

	int value_errors = 0;
	int other_errors = 0;
	int unsigned cycle = 0;
	int unsigned timeout_limit = 100000;
	int num_records = 0;
	int outstanding = 0;
	int widx = 0;
	int burst_count = 0;
	bit in_pkt = 0;
	bit hold = 0;
	bit saw_full = 0;
	bit prev_reset = 1;

	arp_tx_top dut0 (
		.clk(clk),
		.reset(reset),
		.local_mac(my_mac),
		.local_ip(my_ip),
		.req_valid(req_valid),
		.req_entry(req_entry),
		.rep_valid(rep_valid),
		.rep_entry(rep_entry),
		.credit_return(credit_return),
		.req_ready(req_ready),
		.rep_ready(rep_ready),
		.word_valid(word_valid),
		.word(word),
		.dest_mac(dest_mac)
	);

	always #5 clk = ~clk;

	task check_word(input string name, input arp_pkg::arp_word_t got,
			input arp_pkg::arp_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task check_mac(input string name, input arp_pkg::mac_addr_t got,
			input arp_pkg::mac_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task check_oper(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task complain(input string what);
		other_errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	// compares a finished packet with the head of the queue for its kind
	task finish_packet;
		exp_rec_t exp;
		arp_pkg::arp_word_t ew [arp_pkg::arp_frame_words];
		logic [15:0] oper;
		begin
			oper = pkt_words[1].data[15:0];
			if (widx != arp_pkg::arp_frame_words) begin
				complain("packet ended with the wrong number of words");
				return;
			end
			// a wrong opcode still consumes a pending record of either kind
			if (oper == arp_pkg::arp_oper_request && exp_req.size() != 0) begin
				exp = exp_req.pop_front();
			end else if (oper == arp_pkg::arp_oper_reply && exp_rep.size() != 0) begin
				exp = exp_rep.pop_front();
			end else if (exp_req.size() != 0) begin
				exp = exp_req.pop_front();
			end else if (exp_rep.size() != 0) begin
				exp = exp_rep.pop_front();
			end else begin
				complain("packet has no matching pending record");
				return;
			end
			ew[0] = '{{arp_pkg::arp_htype, arp_pkg::arp_ptype}, 1'b1, 1'b0};
			ew[1] = '{{arp_pkg::arp_hlen, arp_pkg::arp_plen, exp.oper}, 1'b0, 1'b0};
			ew[2] = '{my_mac[47:16], 1'b0, 1'b0};
			ew[3] = '{{my_mac[15:0], my_ip[31:16]}, 1'b0, 1'b0};
			ew[4] = '{{my_ip[15:0], exp.tha[47:32]}, 1'b0, 1'b0};
			ew[5] = '{exp.tha[31:0], 1'b0, 1'b0};
			ew[6] = '{exp.tpa, 1'b0, 1'b1};
			for (int i = 0; i < arp_pkg::arp_frame_words; i++)
				check_word($sformatf("word[%0d]", i), pkt_words[i], ew[i]);
			check_oper("oper", oper, exp.oper);
			check_mac("dest_mac", pkt_dest, exp.dest);
		end
	endtask

	// sink model, returns one credit per word after a short random delay
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (reset) begin
			credit_return <= 1'b0;
		end else if (!hold && due.size() != 0 && due[0] <= cycle) begin
			credit_return <= 1'b1;
			void'(due.pop_front());
		end else begin
			credit_return <= 1'b0;
		end
		if (cycle >= timeout_limit) begin
			$display("run timed out with packets missing");
			$display("test failed");
			$finish;
		end
	end

	// monitor, sampled away from the rising edge
	always @(negedge clk) begin
		if (reset || prev_reset) begin
			if (word_valid !== 1'b0 || req_ready !== 1'b1 || rep_ready !== 1'b1)
				complain("wrong output state during or right after reset");
		end
		prev_reset = reset;
		if (!reset) begin
			if (in_pkt && !word_valid && outstanding < arp_pkg::tx_credits)
				complain("packet stalled while credits were available");
			if (word_valid) begin
				outstanding++;
				if (outstanding > arp_pkg::tx_credits)
					complain("more words in flight than credits granted");
				due.push_back(cycle + 1 + $urandom_range(3, 0));
				if (word.sof) begin
					if (in_pkt)
						complain("new packet started before the last one ended");
					in_pkt = 1;
					widx = 0;
					pkt_dest = dest_mac;
				end
				if (!in_pkt) begin
					complain("word sent outside a packet");
				end else if (widx >= arp_pkg::arp_frame_words) begin
					complain("packet longer than seven words");
					in_pkt = 0;
				end else begin
					pkt_words[widx] = word;
					widx++;
					if (word.eof) begin
						finish_packet();
						in_pkt = 0;
					end
				end
			end
			if (credit_return)
				outstanding--;
		end
	end

	task drive_record(input int idx);
		logic [3:0] kind;
		int gap;
		exp_rec_t rec;
		bit accepted;
		bit rdy;
		begin
			kind = data_mem[6*idx][3:0];
			gap = int'(data_mem[6*idx+1][7:0]);
			rec.tpa = data_mem[6*idx+2][31:0];
			rec.tha = data_mem[6*idx+3];
			rec.oper = data_mem[6*idx+4][15:0];
			rec.dest = data_mem[6*idx+5];
			if (kind != 4'd2 && hold) begin
				complain("request burst never filled the queue");
				hold = 0;
			end
			if (gap != 0 || (kind == 4'd2 && !hold && !saw_full)) begin
				req_valid <= 1'b0;
				rep_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			// a burst starts from an empty pipe, then credits are withheld
			if (kind == 4'd2 && !hold && !saw_full) begin
				while (exp_req.size() != 0 || exp_rep.size() != 0 || outstanding != 0)
					@(posedge clk);
				hold = 1;
				burst_count = 0;
			end
			if (kind == 4'd1) begin
				req_valid <= 1'b0;
				rep_valid <= 1'b1;
				rep_entry <= '{rec.tpa, rec.tha};
			end else begin
				rep_valid <= 1'b0;
				req_valid <= 1'b1;
				req_entry <= '{rec.tpa};
			end
			accepted = 0;
			while (!accepted) begin
				@(negedge clk);
				rdy = (kind == 4'd1) ? rep_ready : req_ready;
				if (!rdy && hold && kind == 4'd2) begin
					saw_full = 1;
					if (burst_count != arp_pkg::queue_depth + 1)
						complain($sformatf("req_ready fell after %0d accepts", burst_count));
					hold = 0;
				end
				@(posedge clk);
				if (rdy) begin
					accepted = 1;
					if (kind == 4'd1)
						exp_rep.push_back(rec);
					else
						exp_req.push_back(rec);
					if (kind == 4'd2)
						burst_count++;
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'h904f_9f11));
		reset = 1'b1;
		req_valid = 1'b0;
		rep_valid = 1'b0;
		credit_return = 1'b0;
		req_entry = '0;
		rep_entry = '0;
		$readmemh("arp_tx_testdata.txt", data_mem);
		while (num_records < max_records && data_mem[6*num_records] !== 48'hf)
			num_records++;
		timeout_limit = 200 + 64 * num_records;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < num_records; i++)
			drive_record(i);
		if (hold) begin
			complain("request burst never filled the queue");
			hold = 0;
		end
		req_valid <= 1'b0;
		rep_valid <= 1'b0;
		while (exp_req.size() != 0 || exp_rep.size() != 0 || outstanding != 0 || in_pkt)
			@(posedge clk);
		repeat (4) @(posedge clk);
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: arp_tx_testdata.txt
// kind (0 request, 1 reply, 2 request in credit-withheld burst, f end)
// gap_cycles tpa tha expected_oper expected_dest_mac
0 00 c0a80101 000000000000 0001 ffffffffffff
1 03 c0a80102 0a1b2c3d4e5f 0002 0a1b2c3d4e5f
0 00 c0a80103 000000000000 0001 ffffffffffff
0 00 c0a80104 000000000000 0001 ffffffffffff
1 00 c0a80105 001122334455 0002 001122334455
1 00 c0a80106 66778899aabb 0002 66778899aabb
0 00 c0a80107 000000000000 0001 ffffffffffff
1 00 c0a80108 ccddeeff0011 0002 ccddeeff0011
0 05 0a000001 000000000000 0001 ffffffffffff
1 00 0a000002 deadbeef0001 0002 deadbeef0001
1 00 0a000003 deadbeef0002 0002 deadbeef0002
1 00 0a000004 deadbeef0003 0002 deadbeef0003
1 00 0a000005 deadbeef0004 0002 deadbeef0004
1 00 0a000006 deadbeef0005 0002 deadbeef0005
0 00 0a000007 000000000000 0001 ffffffffffff
2 00 ac100001 000000000000 0001 ffffffffffff
2 00 ac100002 000000000000 0001 ffffffffffff
2 00 ac100003 000000000000 0001 ffffffffffff
2 00 ac100004 000000000000 0001 ffffffffffff
2 00 ac100005 000000000000 0001 ffffffffffff
2 00 ac100006 000000000000 0001 ffffffffffff
2 00 ac100007 000000000000 0001 ffffffffffff
1 02 ac100010 a0b0c0d0e0f0 0002 a0b0c0d0e0f0
0 00 ac100011 000000000000 0001 ffffffffffff
1 01 ac100012 fedcba987654 0002 fedcba987654
0 00 ac100013 000000000000 0001 ffffffffffff
f 00 00000000 000000000000 0000 000000000000

// File: build.f
arp_pkg.sv
arp_pending_queue.sv
arp_frame_tx.sv
arp_tx_top.sv
arp_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ARP transmit testbench with Verilator
rm -f sim.log
verilator --binary -Wno-fatal --top-module arp_tx_tb -f build.f -o arp_tx_sim > build.log 2>&1 \
	&& ./obj_dir/arp_tx_sim > sim.log 2>&1 \
	|| echo "test failed" >> sim.log
if grep -q "test failed" sim.log; then
	exit 1
fi
grep -q "test passed" sim.log
